// ==== src/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

  ////////////////////
  // Array geometry
  ////////////////////

  // Square matrix edge and PE grid size
  localparam int MAT_SIZE = 4;

  // Signed element width
  localparam int DATA_W = 8;

  // Memory side widths
  localparam int ADDR_W = 11;
  localparam int STRIDE_W = 8;

  // Operand register, product register, accumulator
  localparam int MAC_STAGES = 3;

  ////////////////////
  // Data path types
  ////////////////////

  typedef logic signed [DATA_W-1:0] elem_t;

  // Lane 0 sits in the low byte
  typedef elem_t [MAT_SIZE-1:0] word_t;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRIDE_W-1:0] stride_t;

endpackage

`default_nettype wire

// ==== src/matmul_timing_pkg.sv ====
`default_nettype none

package matmul_timing_pkg;

  ////////////////////
  // Run counter
  ////////////////////

  localparam int CNT_W = 8;

  typedef logic [CNT_W-1:0] count_t;

  // Count of the last fetch cycle
  localparam count_t FETCH_LAST = count_t'(matmul_pkg::MAT_SIZE - 1);

  // Count at which the last accumulator update is visible
  // Skew of both operands plus the MAC pipeline
  localparam count_t LATCH_CNT =
    count_t'(3 * matmul_pkg::MAT_SIZE - 2 + matmul_pkg::MAC_STAGES);

  ////////////////////
  // Control FSM
  ////////////////////

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    COMPUTE,
    DRAIN,
    DONE,
    HOLD
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/cycle_counter.sv ====
`default_nettype none
`timescale 1ns/1ns

module cycle_counter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      i_run,
  output matmul_timing_pkg::count_t o_count
);

  // Zero while idle so every run starts from count 0
  // Sticks at all ones instead of rolling over
  always_ff @(posedge clk) begin
    if (reset || !i_run) begin
      o_count <= '0;
    end else if (o_count != '1) begin
      o_count <= o_count + matmul_timing_pkg::count_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== src/matmul_control.sv ====
`default_nettype none
`timescale 1ns/1ns

module matmul_control (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      i_start,
  input  matmul_timing_pkg::count_t i_count,
  output logic                      o_run,
  output logic                      o_fetch,
  output logic                      o_latch,
  output logic                      o_shift,
  output logic                      o_clear,
  output logic                      o_done
);

  matmul_timing_pkg::ctrl_state_t state_q;
  matmul_timing_pkg::ctrl_state_t state_d;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      matmul_timing_pkg::IDLE: state_d = matmul_timing_pkg::FETCH;
      matmul_timing_pkg::FETCH: begin
        if (i_count == matmul_timing_pkg::FETCH_LAST) begin
          state_d = matmul_timing_pkg::COMPUTE;
        end
      end
      matmul_timing_pkg::COMPUTE: begin
        if (i_count == matmul_timing_pkg::LATCH_CNT) begin
          state_d = matmul_timing_pkg::DRAIN;
        end
      end
      // One column per cycle after the latch
      matmul_timing_pkg::DRAIN: begin
        if (i_count == matmul_timing_pkg::count_t'(matmul_timing_pkg::LATCH_CNT +
                                                   matmul_pkg::MAT_SIZE)) begin
          state_d = matmul_timing_pkg::DONE;
        end
      end
      matmul_timing_pkg::DONE: state_d = matmul_timing_pkg::HOLD;
      // Parked until start is released
      matmul_timing_pkg::HOLD: state_d = matmul_timing_pkg::HOLD;
      default: state_d = matmul_timing_pkg::IDLE;
    endcase
    // Start low aborts from any state
    if (!i_start) begin
      state_d = matmul_timing_pkg::IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= matmul_timing_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // Strobes
  ////////////////////

  // Count 0 is the first FETCH cycle
  assign o_run   = i_start && (state_q != matmul_timing_pkg::IDLE);
  assign o_fetch = (state_q == matmul_timing_pkg::FETCH);
  assign o_latch = (state_q == matmul_timing_pkg::COMPUTE) &&
                   (i_count == matmul_timing_pkg::LATCH_CNT);
  assign o_shift = (state_q == matmul_timing_pkg::DRAIN);
  assign o_done  = (state_q == matmul_timing_pkg::DONE);

  // Clear the data path right away when start drops
  assign o_clear = !i_start || (state_q == matmul_timing_pkg::IDLE);

  // Done sits one count past the last drained column
  a_done_pulse : assert property (
    @(posedge clk) disable iff (reset)
    o_done |-> (i_count == matmul_timing_pkg::count_t'(matmul_timing_pkg::LATCH_CNT +
                                                        matmul_pkg::MAT_SIZE + 1))
  ) else $error("done away from the end of the drain");

endmodule

`default_nettype wire

// ==== src/operand_feeder.sv ====
`default_nettype none
`timescale 1ns/1ns

module operand_feeder (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_clear,
  input  logic                i_fetch,
  input  matmul_pkg::addr_t   i_addr_a,
  input  matmul_pkg::addr_t   i_addr_b,
  input  matmul_pkg::stride_t i_stride_a,
  input  matmul_pkg::stride_t i_stride_b,
  input  matmul_pkg::word_t   i_a_data,
  input  matmul_pkg::word_t   i_b_data,
  output matmul_pkg::addr_t   o_a_addr,
  output matmul_pkg::addr_t   o_b_addr,
  output matmul_pkg::elem_t   o_a_lane [matmul_pkg::MAT_SIZE],
  output matmul_pkg::elem_t   o_b_lane [matmul_pkg::MAT_SIZE]
);

  // Fetch strobe aligned with the memory read data
  logic fetch_d;

  ////////////////////
  // Address walk
  ////////////////////

  // Base is parked on the bus while idle
  // Each fetch cycle steps to the next word
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_a_addr <= i_addr_a;
      o_b_addr <= i_addr_b;
    end else if (i_fetch) begin
      o_a_addr <= o_a_addr + matmul_pkg::addr_t'(i_stride_a);
      o_b_addr <= o_b_addr + matmul_pkg::addr_t'(i_stride_b);
    end
  end

  // One cycle of memory latency
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      fetch_d <= 1'b0;
    end else begin
      fetch_d <= i_fetch;
    end
  end

  ////////////////////
  // Diagonal skew
  ////////////////////

  for (genvar i = 0; i < matmul_pkg::MAT_SIZE; i++) begin : gen_lane
    matmul_pkg::elem_t a_qual;
    matmul_pkg::elem_t b_qual;

    // Zero outside the data window keeps the accumulators still
    assign a_qual = fetch_d ? i_a_data[i] : '0;
    assign b_qual = fetch_d ? i_b_data[i] : '0;

    if (i == 0) begin : gen_direct
      assign o_a_lane[i] = a_qual;
      assign o_b_lane[i] = b_qual;
    end else begin : gen_skew
      // Lane i trails lane 0 by i cycles
      matmul_pkg::elem_t a_sr [i];
      matmul_pkg::elem_t b_sr [i];

      always_ff @(posedge clk) begin
        if (reset || i_clear) begin
          for (int s = 0; s < i; s++) begin
            a_sr[s] <= '0;
            b_sr[s] <= '0;
          end
        end else begin
          a_sr[0] <= a_qual;
          b_sr[0] <= b_qual;
          for (int s = 1; s < i; s++) begin
            a_sr[s] <= a_sr[s-1];
            b_sr[s] <= b_sr[s-1];
          end
        end
      end

      assign o_a_lane[i] = a_sr[i-1];
      assign o_b_lane[i] = b_sr[i-1];
    end
  end

endmodule

`default_nettype wire

// ==== src/processing_element.sv ====
`default_nettype none
`timescale 1ns/1ns

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_acc
);

  // Stage 1 operands double as the forwarded values
  matmul_pkg::elem_t a_q;
  matmul_pkg::elem_t b_q;

  // Stage 2 full width signed product
  logic signed [2*matmul_pkg::DATA_W-1:0] prod_q;

  // Product clipped to the element range
  matmul_pkg::elem_t prod_sat;

  // Stage 3 accumulator
  matmul_pkg::elem_t acc_q;

  ////////////////////
  // Saturation
  ////////////////////

  // Fits when the top bits are all copies of the sign
  always_comb begin
    if (prod_q[2*matmul_pkg::DATA_W-1:matmul_pkg::DATA_W-1] == '0 ||
        prod_q[2*matmul_pkg::DATA_W-1:matmul_pkg::DATA_W-1] == '1) begin
      prod_sat = prod_q[matmul_pkg::DATA_W-1:0];
    end else begin
      // Clip to +127 or -128
      prod_sat = {prod_q[2*matmul_pkg::DATA_W-1],
                  {(matmul_pkg::DATA_W-1){~prod_q[2*matmul_pkg::DATA_W-1]}}};
    end
  end

  ////////////////////
  // MAC pipeline
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
      acc_q  <= '0;
    end else begin
      a_q    <= i_a;
      b_q    <= i_b;
      // Both operands are signed so the product extends correctly
      prod_q <= a_q * b_q;
      // Accumulate wraps at 8 bits
      acc_q  <= acc_q + prod_sat;
    end
  end

  // A travels right and B travels down
  assign o_a   = a_q;
  assign o_b   = b_q;
  assign o_acc = acc_q;

endmodule

`default_nettype wire

// ==== src/pe_array.sv ====
`default_nettype none
`timescale 1ns/1ns

module pe_array (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a_lane [matmul_pkg::MAT_SIZE],
  input  matmul_pkg::elem_t i_b_lane [matmul_pkg::MAT_SIZE],
  output matmul_pkg::elem_t o_c [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE]
);

  // Operands leaving each cell
  matmul_pkg::elem_t a_fwd [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE];
  matmul_pkg::elem_t b_fwd [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE];

  for (genvar i = 0; i < matmul_pkg::MAT_SIZE; i++) begin : gen_row
    for (genvar j = 0; j < matmul_pkg::MAT_SIZE; j++) begin : gen_col
      matmul_pkg::elem_t a_in;
      matmul_pkg::elem_t b_in;

      // Left edge takes the A lane of its row
      if (j == 0) begin : gen_a_edge
        assign a_in = i_a_lane[i];
      end else begin : gen_a_link
        assign a_in = a_fwd[i][j-1];
      end

      // Top edge takes the B lane of its column
      if (i == 0) begin : gen_b_edge
        assign b_in = i_b_lane[j];
      end else begin : gen_b_link
        assign b_in = b_fwd[i-1][j];
      end

      processing_element u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_in),
        .i_b     (b_in),
        .o_a     (a_fwd[i][j]),
        .o_b     (b_fwd[i][j]),
        .o_acc   (o_c[i][j])
      );
    end
  end

endmodule

`default_nettype wire

// ==== src/result_drain.sv ====
`default_nettype none
`timescale 1ns/1ns

module result_drain (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_clear,
  input  logic                i_latch,
  input  logic                i_shift,
  input  matmul_pkg::addr_t   i_addr_c,
  input  matmul_pkg::stride_t i_stride_c,
  input  matmul_pkg::elem_t   i_c [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE],
  output matmul_pkg::word_t   o_c_data,
  output matmul_pkg::addr_t   o_c_addr,
  output logic                o_c_valid
);

  // Column shift register with column 0 at the head
  matmul_pkg::word_t col_q [matmul_pkg::MAT_SIZE];

  // One valid bit per held column
  logic [matmul_pkg::MAT_SIZE-1:0] vld_q;

  ////////////////////
  // Valid tracking
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      vld_q <= '0;
    end else if (i_latch) begin
      vld_q <= '1;
    end else if (i_shift) begin
      vld_q <= vld_q >> 1;
    end
  end

  ////////////////////
  // Columns and addresses
  ////////////////////

  always_ff @(posedge clk) begin
    if (i_latch) begin
      // Row i of column j lands in lane i
      for (int j = 0; j < matmul_pkg::MAT_SIZE; j++) begin
        for (int i = 0; i < matmul_pkg::MAT_SIZE; i++) begin
          col_q[j][i] <= i_c[i][j];
        end
      end
      o_c_addr <= i_addr_c;
    end else if (i_shift) begin
      for (int j = 0; j < matmul_pkg::MAT_SIZE - 1; j++) begin
        col_q[j] <= col_q[j+1];
      end
      col_q[matmul_pkg::MAT_SIZE-1] <= '0;
      // Addresses count up from the base
      o_c_addr <= o_c_addr + matmul_pkg::addr_t'(i_stride_c);
    end
  end

  assign o_c_data  = col_q[0];
  assign o_c_valid = vld_q[0];

  a_valid_len : assert property (
    @(posedge clk) disable iff (reset)
    o_c_valid [*matmul_pkg::MAT_SIZE] |=> !o_c_valid
  ) else $error("result valid longer than one matrix");

endmodule

`default_nettype wire

// ==== src/matmul_systolic.sv ====
`default_nettype none
`timescale 1ns/1ns

module matmul_systolic (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_start,
  input  matmul_pkg::addr_t   i_addr_a,
  input  matmul_pkg::addr_t   i_addr_b,
  input  matmul_pkg::addr_t   i_addr_c,
  input  matmul_pkg::stride_t i_stride_a,
  input  matmul_pkg::stride_t i_stride_b,
  input  matmul_pkg::stride_t i_stride_c,
  input  matmul_pkg::word_t   i_a_data,
  input  matmul_pkg::word_t   i_b_data,
  output matmul_pkg::addr_t   o_a_addr,
  output matmul_pkg::addr_t   o_b_addr,
  output matmul_pkg::addr_t   o_c_addr,
  output matmul_pkg::word_t   o_c_data,
  output logic                o_c_valid,
  output logic                o_done
);

  ////////////////////
  // Control
  ////////////////////

  matmul_timing_pkg::count_t count;
  logic run;
  logic fetch;
  logic latch;
  logic shift;
  logic clear;

  cycle_counter u_counter (
    .clk     (clk),
    .reset   (reset),
    .i_run   (run),
    .o_count (count)
  );

  matmul_control u_control (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .i_count (count),
    .o_run   (run),
    .o_fetch (fetch),
    .o_latch (latch),
    .o_shift (shift),
    .o_clear (clear),
    .o_done  (o_done)
  );

  ////////////////////
  // Data path
  ////////////////////

  matmul_pkg::elem_t a_lane [matmul_pkg::MAT_SIZE];
  matmul_pkg::elem_t b_lane [matmul_pkg::MAT_SIZE];
  matmul_pkg::elem_t c_grid [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE];

  operand_feeder u_feeder (
    .clk        (clk),
    .reset      (reset),
    .i_clear    (clear),
    .i_fetch    (fetch),
    .i_addr_a   (i_addr_a),
    .i_addr_b   (i_addr_b),
    .i_stride_a (i_stride_a),
    .i_stride_b (i_stride_b),
    .i_a_data   (i_a_data),
    .i_b_data   (i_b_data),
    .o_a_addr   (o_a_addr),
    .o_b_addr   (o_b_addr),
    .o_a_lane   (a_lane),
    .o_b_lane   (b_lane)
  );

  pe_array u_array (
    .clk      (clk),
    .reset    (reset),
    .i_clear  (clear),
    .i_a_lane (a_lane),
    .i_b_lane (b_lane),
    .o_c      (c_grid)
  );

  result_drain u_drain (
    .clk        (clk),
    .reset      (reset),
    .i_clear    (clear),
    .i_latch    (latch),
    .i_shift    (shift),
    .i_addr_c   (i_addr_c),
    .i_stride_c (i_stride_c),
    .i_c        (c_grid),
    .o_c_data   (o_c_data),
    .o_c_addr   (o_c_addr),
    .o_c_valid  (o_c_valid)
  );

endmodule

`default_nettype wire

// ==== bench/tb_matmul.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_matmul;

  localparam int N = matmul_pkg::MAT_SIZE;
  localparam int LATCH = int'(matmul_timing_pkg::LATCH_CNT);
  // Seven start sequences over the five tests
  localparam int NUM_RUNS = 7;
  localparam int TIMEOUT_CYCLES = 2 * NUM_RUNS * (LATCH + 12);

  logic clk = 1'b0;
  logic reset;
  logic start;
  matmul_pkg::addr_t addr_a;
  matmul_pkg::addr_t addr_b;
  matmul_pkg::addr_t addr_c;
  matmul_pkg::stride_t stride_a;
  matmul_pkg::stride_t stride_b;
  matmul_pkg::stride_t stride_c;
  matmul_pkg::word_t a_data = '0;
  matmul_pkg::word_t b_data = '0;
  matmul_pkg::addr_t a_addr;
  matmul_pkg::addr_t b_addr;
  matmul_pkg::addr_t c_addr;
  matmul_pkg::word_t c_data;
  logic c_valid;
  logic done;

  // Memory images behind the A and B read ports
  matmul_pkg::word_t mem_a [2**matmul_pkg::ADDR_W];
  matmul_pkg::word_t mem_b [2**matmul_pkg::ADDR_W];

  // Operands and expected result of the current run
  matmul_pkg::elem_t mat_a [N][N];
  matmul_pkg::elem_t mat_b [N][N];
  matmul_pkg::elem_t mat_c [N][N];

  int seed = 32'hace6_ad1c;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle_cnt = 0;

  matmul_systolic dut (
    .clk        (clk),
    .reset      (reset),
    .i_start    (start),
    .i_addr_a   (addr_a),
    .i_addr_b   (addr_b),
    .i_addr_c   (addr_c),
    .i_stride_a (stride_a),
    .i_stride_b (stride_b),
    .i_stride_c (stride_c),
    .i_a_data   (a_data),
    .i_b_data   (b_data),
    .o_a_addr   (a_addr),
    .o_b_addr   (b_addr),
    .o_c_addr   (c_addr),
    .o_c_data   (c_data),
    .o_c_valid  (c_valid),
    .o_done     (done)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // Synchronous read ports, data one cycle after the address
  always @(posedge clk) begin
    a_data <= mem_a[a_addr];
    b_data <= mem_b[b_addr];
  end

  // Hard stop if a run never finishes
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles, tests did not finish", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input matmul_pkg::word_t got,
                            input matmul_pkg::word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input matmul_pkg::addr_t got,
                            input matmul_pkg::addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Word k sits at base plus k strides, wrapping in the address space
  function automatic matmul_pkg::addr_t step_addr(input matmul_pkg::addr_t base,
                                                  input matmul_pkg::stride_t stride,
                                                  input int k);
    return matmul_pkg::addr_t'(int'(base) + k * int'(stride));
  endfunction

  // Full signed product clipped to the element range
  function automatic matmul_pkg::elem_t sat_product(input matmul_pkg::elem_t a,
                                                    input matmul_pkg::elem_t b);
    int p;
    p = int'(a) * int'(b);
    if (p > 127) begin
      return matmul_pkg::elem_t'(127);
    end else if (p < -128) begin
      return matmul_pkg::elem_t'(-128);
    end
    return matmul_pkg::elem_t'(p);
  endfunction

  // Sum wraps at the element width
  task automatic compute_reference();
    int i;
    int j;
    int k;
    for (i = 0; i < N; i++) begin
      for (j = 0; j < N; j++) begin
        mat_c[i][j] = '0;
        for (k = 0; k < N; k++) begin
          mat_c[i][j] = mat_c[i][j] + sat_product(mat_a[i][k], mat_b[k][j]);
        end
      end
    end
  endtask

  // Magnitude up to mag, or any byte for 128 and above
  function automatic matmul_pkg::elem_t rand_elem(input int mag);
    int r;
    r = $random(seed);
    if (mag < 128) begin
      r = r % (mag + 1);
    end
    return matmul_pkg::elem_t'(r);
  endfunction

  task automatic randomize_operands(input int mag);
    int i;
    int j;
    for (i = 0; i < N; i++) begin
      for (j = 0; j < N; j++) begin
        mat_a[i][j] = rand_elem(mag);
        mat_b[i][j] = rand_elem(mag);
      end
    end
  endtask

  ////////////////////
  // Memory setup
  ////////////////////

  // Odd multiplier spreads every address bit over the word
  task automatic fill_memories();
    int n;
    for (n = 0; n < 2**matmul_pkg::ADDR_W; n++) begin
      mem_a[matmul_pkg::addr_t'(n)] = matmul_pkg::word_t'(n * 32'h9e37_79b1);
      mem_b[matmul_pkg::addr_t'(n)] =
        matmul_pkg::word_t'((n * 32'h9e37_79b1) ^ 32'h5a5a_5a5a);
    end
  endtask

  task automatic load_mems(input matmul_pkg::addr_t a_base, input matmul_pkg::stride_t a_str,
                           input matmul_pkg::addr_t b_base, input matmul_pkg::stride_t b_str);
    int k;
    int i;
    matmul_pkg::addr_t a_at;
    matmul_pkg::addr_t b_at;
    @(negedge clk);
    for (k = 0; k < N; k++) begin
      a_at = step_addr(a_base, a_str, k);
      b_at = step_addr(b_base, b_str, k);
      // A words hold columns, B words hold rows
      for (i = 0; i < N; i++) begin
        mem_a[a_at][i] = mat_a[i][k];
        mem_b[b_at][i] = mat_b[k][i];
      end
    end
  endtask

  ////////////////////
  // Run sequences
  ////////////////////

  task automatic run_matmul(input matmul_pkg::addr_t a_base, input matmul_pkg::stride_t a_str,
                            input matmul_pkg::addr_t b_base, input matmul_pkg::stride_t b_str,
                            input matmul_pkg::addr_t c_base, input matmul_pkg::stride_t c_str);
    int k;
    int i;
    int j;
    int edge_idx;
    matmul_pkg::word_t exp_col;
    load_mems(a_base, a_str, b_base, b_str);
    @(posedge clk);
    addr_a <= a_base;
    addr_b <= b_base;
    addr_c <= c_base;
    stride_a <= a_str;
    stride_b <= b_str;
    stride_c <= c_str;
    start <= 1'b1;
    // Edge 0 samples start high
    @(posedge clk);
    for (k = 0; k < N; k++) begin
      @(negedge clk);
      check_addr("o_a_addr", a_addr, step_addr(a_base, a_str, k));
      check_addr("o_b_addr", b_addr, step_addr(b_base, b_str, k));
    end
    // Wait for the first column, bounded
    edge_idx = N - 1;
    while (!c_valid && edge_idx < LATCH + 8) begin
      @(negedge clk);
      edge_idx++;
    end
    if (!c_valid) begin
      $display("no result column within %0d cycles of start", edge_idx);
      errors++;
      return;
    end
    if (edge_idx != LATCH + 1) begin
      $display("first result column after edge %0d instead of edge %0d", edge_idx, LATCH + 1);
      errors++;
    end
    for (j = 0; j < N; j++) begin
      check_bit("o_c_valid", c_valid, 1'b1);
      check_bit("o_done", done, 1'b0);
      check_addr("o_c_addr", c_addr, step_addr(c_base, c_str, j));
      for (i = 0; i < N; i++) begin
        exp_col[i] = mat_c[i][j];
      end
      check_word("o_c_data", c_data, exp_col);
      @(negedge clk);
    end
    // Done right after the last column, for one cycle
    check_bit("o_c_valid", c_valid, 1'b0);
    check_bit("o_done", done, 1'b1);
    @(negedge clk);
    check_bit("o_done", done, 1'b0);
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit("o_c_valid", c_valid, 1'b0);
    check_bit("o_done", done, 1'b0);
    check_addr("o_a_addr", a_addr, a_base);
    check_addr("o_b_addr", b_addr, b_base);
  endtask

  // Start dropped partway through the computation
  task automatic abort_run(input matmul_pkg::addr_t a_base, input matmul_pkg::addr_t b_base);
    int n;
    @(posedge clk);
    addr_a <= a_base;
    addr_b <= b_base;
    start <= 1'b1;
    repeat (LATCH / 2) @(posedge clk);
    start <= 1'b0;
    for (n = 0; n < LATCH + N; n++) begin
      @(negedge clk);
      check_bit("o_c_valid", c_valid, 1'b0);
      check_bit("o_done", done, 1'b0);
    end
    check_addr("o_a_addr", a_addr, a_base);
    check_addr("o_b_addr", b_addr, b_base);
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_at_start);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_identity();
    int errs_at_start;
    int i;
    int j;
    errs_at_start = errors;
    randomize_operands(128);
    // C must come back as B itself
    for (i = 0; i < N; i++) begin
      for (j = 0; j < N; j++) begin
        mat_a[i][j] = (i == j) ? matmul_pkg::elem_t'(1) : matmul_pkg::elem_t'(0);
        mat_c[i][j] = mat_b[i][j];
      end
    end
    run_matmul(11'h010, 8'd1, 11'h100, 8'd1, 11'h200, 8'd4);
    finish_test("identity", errs_at_start);
  endtask

  task automatic test_small_random();
    int errs_at_start;
    errs_at_start = errors;
    // At most 4 x 25, so neither clipping nor wrap
    randomize_operands(5);
    compute_reference();
    run_matmul(11'h040, 8'd2, 11'h080, 8'd3, 11'h300, 8'd1);
    finish_test("small random", errs_at_start);
  endtask

  task automatic test_saturation();
    int errs_at_start;
    int i;
    int j;
    matmul_pkg::elem_t pick [4];
    errs_at_start = errors;
    pick[0] = 127;
    pick[1] = -127;
    pick[2] = -128;
    pick[3] = 100;
    // Every product clips, and the sums of four wrap
    for (i = 0; i < N; i++) begin
      for (j = 0; j < N; j++) begin
        mat_a[i][j] = pick[$unsigned($random(seed)) % 4];
        mat_b[i][j] = pick[$unsigned($random(seed)) % 4];
      end
    end
    compute_reference();
    run_matmul(11'h000, 8'd8, 11'h7f8, 8'd2, 11'h000, 8'h10);
    finish_test("saturation and wrap", errs_at_start);
  endtask

  task automatic test_address_stepping();
    int errs_at_start;
    errs_at_start = errors;
    // A and C walk past the top of the address space
    randomize_operands(128);
    compute_reference();
    run_matmul(11'h7f0, 8'h15, 11'h3ff, 8'h81, 11'h7fc, 8'h03);
    finish_test("address stepping", errs_at_start);
  endtask

  task automatic test_done_and_idle();
    int errs_at_start;
    errs_at_start = errors;
    randomize_operands(128);
    compute_reference();
    run_matmul(11'h120, 8'd4, 11'h220, 8'd4, 11'h420, 8'd1);
    abort_run(11'h120, 11'h220);
    // Fresh data on the same addresses after the abort
    randomize_operands(128);
    compute_reference();
    run_matmul(11'h120, 8'd4, 11'h220, 8'd4, 11'h420, 8'd1);
    finish_test("done and idle", errs_at_start);
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    addr_a = '0;
    addr_b = '0;
    addr_c = '0;
    stride_a = '0;
    stride_b = '0;
    stride_c = '0;
    fill_memories();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_identity();
    test_small_random();
    test_saturation();
    test_address_stepping();
    test_done_and_idle();
    $display("tests passed %0d, failed %0d, failed checks %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/matmul_pkg.sv
src/matmul_timing_pkg.sv
src/cycle_counter.sv
src/matmul_control.sv
src/operand_feeder.sv
src/processing_element.sv
src/pe_array.sv
src/result_drain.sv
src/matmul_systolic.sv
bench/tb_matmul.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_matmul
SRCS := $(filter %.sv,$(shell cat verilog.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f --top-module tb_matmul -Mdir obj_dir

# Status comes from the pass line in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
